/* bench/mem1_asserts.sv */
`timescale 1ns/1ps

module mem1_asserts (
    input logic clk,
    input logic rst_n,
    input logic is_store,
    input logic is_sc,
    input logic mem_en,
    input logic wr_en,
    input logic flush
);

    // a flushed access never reaches the cache
    assert property (@(posedge clk) disable iff (!rst_n) !(mem_en && flush))
        else $error("mem_en high while the stage flushes");

    assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> is_store)
        else $error("wr_en high without a store");

    // link still cleared by reset
    assert property (@(posedge clk) $rose(rst_n) |-> !(is_sc && wr_en))
        else $error("sc wrote in the first cycle after reset");

endmodule

bind mem1_stage mem1_asserts u_asserts (.*);

/* bench/mem1_checker.sv */
`timescale 1ns/1ps

module mem1_checker (
    input  logic                clk,
    input  logic                check_en,
    input  logic [4:0]          chk,       // addr, store, load, exc, link from bit 0
    input  mem1_pkg::paddr_t    paddr, exp_paddr,
    input  logic                uncached, exp_uncached,
    input  mem1_pkg::wstrb_t    wstrb, exp_wstrb,
    input  mem1_pkg::word_t     wdata, exp_wdata,
    input  mem1_pkg::rstrb_t    rstrb, exp_rstrb,
    input  mem1_pkg::acc_size_t acc_size, exp_acc_size,
    input  logic                exception, exp_exception,
    input  mem1_pkg::exc_code_t exc_code, exp_exc_code,
    input  mem1_pkg::vaddr_t    badvaddr, exp_badvaddr,
    input  logic                tlb_refill, exp_tlb_refill,
    input  logic                wr_en, exp_wr_en,
    input  logic                sc_result, exp_sc_result,
    input  logic                mem_en, exp_mem_en,
    input  logic                flush, exp_flush,
    output int                  errors,
    output int                  checks
);

    initial begin
        errors = 0;
        checks = 0;
    end

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        if (exp !== got) begin
            errors++;
            $display("ERROR %s expected %h got %h at %0t", name, exp, got, $time);
        end
    endtask

    // inputs change on the falling edge, so outputs are settled here
    always @(posedge clk) begin
        if (check_en) begin
            if (chk[0]) begin
                compare("paddr", exp_paddr, paddr);
                compare("uncached", exp_uncached, uncached);
            end
            if (chk[1]) begin
                compare("wstrb", exp_wstrb, wstrb);
                compare("wdata", exp_wdata, wdata);
            end
            if (chk[2]) begin
                compare("rstrb", exp_rstrb, rstrb);
                compare("acc_size", exp_acc_size, acc_size);
            end
            if (chk[3]) begin
                compare("exception", exp_exception, exception);
                compare("exc_code", exp_exc_code, exc_code);
                compare("badvaddr", exp_badvaddr, badvaddr);
                compare("tlb_refill", exp_tlb_refill, tlb_refill);
                compare("flush", exp_flush, flush);
                compare("mem_en", exp_mem_en, mem_en);
            end
            if (chk[4]) begin
                compare("wr_en", exp_wr_en, wr_en);
                compare("sc_result", exp_sc_result, sc_result);
                compare("mem_en", exp_mem_en, mem_en);
                compare("flush", exp_flush, flush);
            end
        end
    end

endmodule

/* bench/mem1_tb.sv */
`timescale 1ns/1ps

module mem1_tb;

    typedef struct packed {
        logic                req, is_load, is_store, is_ll, is_sc;
        mem1_pkg::mem_sel_t  dm_sel;
        mem1_pkg::vaddr_t    vaddr;
        mem1_pkg::vaddr_t    pc;
        mem1_pkg::word_t     store_data;
        logic                tlb_found, tlb_v, tlb_d;
        mem1_pkg::pfn_t      tlb_pfn;
        mem1_pkg::cattr_t    tlb_c, k0_attr;
        logic                interrupt, prior_exc, overflow, trap;
        mem1_pkg::exc_code_t prior_code;
        logic [4:0]          chk;  // compared groups: addr, store, load, exc, link from bit 0
        mem1_pkg::paddr_t    exp_paddr;
        logic                exp_uncached;
        mem1_pkg::wstrb_t    exp_wstrb;
        mem1_pkg::word_t     exp_wdata;
        mem1_pkg::rstrb_t    exp_rstrb;
        mem1_pkg::acc_size_t exp_acc_size;
        logic                exp_exception;
        mem1_pkg::exc_code_t exp_exc_code;
        mem1_pkg::vaddr_t    exp_badvaddr;
        logic                exp_tlb_refill, exp_wr_en, exp_sc_result;
        logic                exp_mem_en, exp_flush;
    } row_t;

    logic clk;
    logic rst_n;
    logic check_en;
    logic table_ready;
    row_t cur;
    row_t rows[$];
    int   errors;
    int   checks;

    mem1_pkg::paddr_t    paddr;
    mem1_pkg::word_t     wdata;
    mem1_pkg::vaddr_t    badvaddr;
    mem1_pkg::wstrb_t    wstrb;
    mem1_pkg::rstrb_t    rstrb;
    mem1_pkg::acc_size_t acc_size;
    mem1_pkg::exc_code_t exc_code;
    logic uncached, mem_en, wr_en, exception, tlb_refill, flush, sc_result;

    mem1_stage UUT (
        .req        (cur.req),
        .is_load    (cur.is_load),
        .is_store   (cur.is_store),
        .is_ll      (cur.is_ll),
        .is_sc      (cur.is_sc),
        .dm_sel     (cur.dm_sel),
        .vaddr      (cur.vaddr),
        .pc         (cur.pc),
        .store_data (cur.store_data),
        .tlb_found  (cur.tlb_found),
        .tlb_v      (cur.tlb_v),
        .tlb_d      (cur.tlb_d),
        .tlb_pfn    (cur.tlb_pfn),
        .tlb_c      (cur.tlb_c),
        .k0_attr    (cur.k0_attr),
        .interrupt  (cur.interrupt),
        .overflow   (cur.overflow),
        .trap       (cur.trap),
        .prior_exc  (cur.prior_exc),
        .prior_code (cur.prior_code),
        .eret_flush (1'b0),
        .*
    );

    mem1_checker u_checker (
        .chk            (cur.chk),
        .exp_paddr      (cur.exp_paddr),
        .exp_uncached   (cur.exp_uncached),
        .exp_wstrb      (cur.exp_wstrb),
        .exp_wdata      (cur.exp_wdata),
        .exp_rstrb      (cur.exp_rstrb),
        .exp_acc_size   (cur.exp_acc_size),
        .exp_exception  (cur.exp_exception),
        .exp_exc_code   (cur.exp_exc_code),
        .exp_badvaddr   (cur.exp_badvaddr),
        .exp_tlb_refill (cur.exp_tlb_refill),
        .exp_wr_en      (cur.exp_wr_en),
        .exp_sc_result  (cur.exp_sc_result),
        .exp_mem_en     (cur.exp_mem_en),
        .exp_flush      (cur.exp_flush),
        .*
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    // aligned kseg0 word load, nothing pending
    function automatic row_t base_row();
        row_t r;
        r = '0;
        r.req = 1'b1;
        r.is_load = 1'b1;
        r.dm_sel = mem1_pkg::SEL_LW;
        r.vaddr = 32'h8000_0000;
        r.pc = 32'hbfc0_0103;
        {r.tlb_found, r.tlb_v, r.tlb_d} = 3'b111;
        r.tlb_c = mem1_pkg::CATTR_CACHED;
        r.k0_attr = mem1_pkg::CATTR_CACHED;
        r.prior_code = mem1_pkg::EXC_ADEL; // fetch address error
        return r;
    endfunction

    task automatic add_xlate(input mem1_pkg::vaddr_t va, input mem1_pkg::pfn_t pfn,
                             input mem1_pkg::cattr_t tc, input mem1_pkg::cattr_t k0,
                             input mem1_pkg::paddr_t pa, input logic unc);
        row_t r;
        r = base_row();
        r.vaddr = va;
        r.tlb_pfn = pfn;
        r.tlb_c = tc;
        r.k0_attr = k0;
        r.chk = 5'b00001;
        r.exp_paddr = pa;
        r.exp_uncached = unc;
        rows.push_back(r);
    endtask

    // one select at one byte offset, expected lanes built byte by byte
    task automatic add_lane(input mem1_pkg::mem_sel_t sel, input int off);
        row_t r;
        mem1_pkg::word_t d;
        int src;
        r = base_row();
        d = $urandom;
        r.vaddr = 32'h8000_0100 + off;
        r.store_data = d;
        r.dm_sel = sel;
        r.chk = 5'b00100;
        if (sel <= mem1_pkg::SEL_SWR) begin
            r.is_load = 1'b0;
            r.is_store = 1'b1;
            r.chk = 5'b00010;
        end
        for (int b = 0; b < 4; b++) begin
            case (sel)
                mem1_pkg::SEL_SB: begin
                    r.exp_wstrb[b] = (b == off);
                    src = 0;
                end
                mem1_pkg::SEL_SH: begin
                    r.exp_wstrb[b] = (b / 2 == off / 2);
                    src = b % 2;
                end
                mem1_pkg::SEL_SWL: begin // high register bytes land low
                    src = b + 3 - off;
                    r.exp_wstrb[b] = (src <= 3);
                end
                mem1_pkg::SEL_SWR: begin
                    src = b - off;
                    r.exp_wstrb[b] = (src >= 0);
                end
                default: begin
                    r.exp_wstrb[b] = 1'b1;
                    src = b;
                end
            endcase
            if (src >= 0 && src <= 3) begin
                r.exp_wdata[8*b +: 8] = d[8*src +: 8];
            end
            r.exp_rstrb[b] = (sel == mem1_pkg::SEL_LWL) ? (b >= 3 - off) :
                             (sel == mem1_pkg::SEL_LWR) ? (b <= 3 - off) : 1'b1;
        end
        r.exp_rstrb[4] = 1'b1;
        case (sel)
            mem1_pkg::SEL_LBU: r.exp_rstrb = {3'b000, off[1:0]};
            mem1_pkg::SEL_LB:  r.exp_rstrb = {3'b010, off[1:0]};
            mem1_pkg::SEL_LHU: r.exp_rstrb = {3'b001, off[1], 1'b0};
            mem1_pkg::SEL_LH:  r.exp_rstrb = {3'b011, off[1], 1'b0};
            default: ;
        endcase
        r.exp_acc_size = mem1_pkg::SIZE_WORD;
        if (sel == mem1_pkg::SEL_SB || sel == mem1_pkg::SEL_LB || sel == mem1_pkg::SEL_LBU) begin
            r.exp_acc_size = mem1_pkg::SIZE_BYTE;
        end
        if (sel == mem1_pkg::SEL_SH || sel == mem1_pkg::SEL_LH || sel == mem1_pkg::SEL_LHU) begin
            r.exp_acc_size = mem1_pkg::SIZE_HALF;
        end
        rows.push_back(r);
    endtask

    // flags: {tlb_found, tlb_v, tlb_d, interrupt, prior_exc, overflow, trap}
    task automatic add_exc(input mem1_pkg::vaddr_t va, input mem1_pkg::mem_sel_t sel,
                           input logic st, input logic [6:0] flags,
                           input mem1_pkg::exc_code_t code, input mem1_pkg::vaddr_t bad,
                           input logic refill);
        row_t r;
        r = base_row();
        r.vaddr = va;
        r.dm_sel = sel;
        r.is_store = st;
        r.is_load = ~st;
        {r.tlb_found, r.tlb_v, r.tlb_d, r.interrupt, r.prior_exc, r.overflow, r.trap} = flags;
        r.chk = 5'b01000;
        r.exp_exception = 1'b1;
        r.exp_exc_code = code;
        r.exp_badvaddr = bad;
        r.exp_tlb_refill = refill;
        r.exp_flush = 1'b1;
        r.exp_mem_en = 1'b0;  // flushed access stays off the bus
        rows.push_back(r);
    endtask

    task automatic add_link(input logic ll, input logic sc, input logic ovf,
                            input mem1_pkg::vaddr_t va, input logic exp_sc, input logic exp_wr,
                            input logic exp_men);
        row_t r;
        r = base_row();
        r.vaddr = va;
        r.is_ll = ll;
        r.is_sc = sc;
        r.is_store = sc;
        r.is_load = ~sc;
        r.dm_sel = sc ? mem1_pkg::SEL_SW : mem1_pkg::SEL_LW;
        r.overflow = ovf;
        r.chk = 5'b10000;
        r.exp_sc_result = exp_sc;
        r.exp_wr_en = exp_wr;
        r.exp_mem_en = exp_men;
        r.exp_flush = ovf;  // overflow is the only cause raised here
        rows.push_back(r);
    endtask

    task automatic build_table();
        // ll, sc, overflow, vaddr, sc_result, wr_en, mem_en
        add_link(1'b0, 1'b1, 1'b0, 32'h8000_0300, 1'b0, 1'b0, 1'b0); // no link yet
        add_link(1'b1, 1'b0, 1'b0, 32'h8000_0300, 1'b0, 1'b0, 1'b1);
        add_link(1'b0, 1'b1, 1'b0, 32'h8000_0300, 1'b1, 1'b1, 1'b1);
        add_link(1'b1, 1'b0, 1'b0, 32'h8000_0300, 1'b0, 1'b0, 1'b1);
        add_link(1'b0, 1'b1, 1'b0, 32'h8000_0304, 1'b0, 1'b0, 1'b0); // other address
        add_link(1'b1, 1'b0, 1'b0, 32'h8000_0300, 1'b0, 1'b0, 1'b1);
        add_link(1'b0, 1'b0, 1'b1, 32'h8000_0300, 1'b0, 1'b0, 1'b0); // overflow flush
        add_link(1'b0, 1'b1, 1'b0, 32'h8000_0300, 1'b0, 1'b0, 1'b0);
        // vaddr, pfn, tlb_c, k0_attr, paddr, uncached (cached attribute is 3)
        add_xlate(32'h8000_1234, 20'h00000, 3'd3, 3'd3, 32'h0000_1234, 1'b0);
        add_xlate(32'h8000_1234, 20'h00000, 3'd3, 3'd2, 32'h0000_1234, 1'b1);
        add_xlate(32'ha012_3458, 20'h00000, 3'd3, 3'd3, 32'h0012_3458, 1'b1);
        add_xlate(32'h0040_0abc, 20'h12345, 3'd3, 3'd2, 32'h1234_5abc, 1'b0);
        add_xlate(32'hc000_0ff0, 20'h0a0a0, 3'd2, 3'd3, 32'h0a0a_0ff0, 1'b1);
        for (int s = 0; s <= 11; s++) begin
            for (int o = 0; o < 4; o++) begin
                add_lane(s[3:0], o);
            end
        end
        // vaddr, select, store, flags, code, badvaddr, refill
        add_exc(32'h0000_1000, mem1_pkg::SEL_LW, 1'b0, 7'b0111000, mem1_pkg::EXC_INT,
                32'h0, 1'b1);
        add_exc(32'h8000_0000, mem1_pkg::SEL_LW, 1'b0, 7'b1110110, mem1_pkg::EXC_ADEL,
                32'hbfc0_0103, 1'b0);
        add_exc(32'h8000_0002, mem1_pkg::SEL_LW, 1'b0, 7'b1110001, mem1_pkg::EXC_TR,
                32'h0, 1'b0);
        add_exc(32'h8000_0011, mem1_pkg::SEL_SH, 1'b1, 7'b1110000, mem1_pkg::EXC_ADES,
                32'h8000_0011, 1'b0);
        add_exc(32'h0040_2000, mem1_pkg::SEL_LW, 1'b0, 7'b0110000, mem1_pkg::EXC_TLBL,
                32'h0040_2000, 1'b1);
        add_exc(32'h0040_3000, mem1_pkg::SEL_SW, 1'b1, 7'b1010000, mem1_pkg::EXC_TLBS,
                32'h0040_3000, 1'b0);
        add_exc(32'h0040_4000, mem1_pkg::SEL_SW, 1'b1, 7'b1100000, mem1_pkg::EXC_MOD,
                32'h0040_4000, 1'b0);
    endtask

    initial begin
        void'($urandom(32'h58ef));
        table_ready = 1'b0;
        check_en = 1'b0;
        rst_n = 1'b0;
        cur = base_row();
        build_table();
        table_ready = 1'b1;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            cur = rows[i];
            check_en = 1'b1;
            @(negedge clk);
        end
        check_en = 1'b0;
        #1;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // two cycles per row plus margin for reset
    initial begin
        wait (table_ready);
        #((rows.size() + 20) * 8 * 2);
        $display("timeout: the stimulus loop did not finish in time");
        $display("Test failed");
        $finish;
    end

endmodule

/* rtl/mem1_access_align.sv */
`timescale 1ns/1ps

module mem1_access_align (
    input  mem1_pkg::mem_sel_t  dm_sel,
    input  logic [1:0]          byte_off,
    input  mem1_pkg::word_t     store_data,
    output mem1_pkg::wstrb_t    wstrb,
    output mem1_pkg::word_t     wdata,
    output mem1_pkg::rstrb_t    rstrb,
    output mem1_pkg::acc_size_t acc_size
);

    // byte enables
    always_comb begin
        case (dm_sel)
            mem1_pkg::SEL_SB: begin
                case (byte_off)
                    2'b00:   wstrb = 4'b0001;
                    2'b01:   wstrb = 4'b0010;
                    2'b10:   wstrb = 4'b0100;
                    default: wstrb = 4'b1000;
                endcase
            end
            mem1_pkg::SEL_SH: begin
                wstrb = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            mem1_pkg::SEL_SWL: begin // byte 0 up to the offset
                case (byte_off)
                    2'b00:   wstrb = 4'b0001;
                    2'b01:   wstrb = 4'b0011;
                    2'b10:   wstrb = 4'b0111;
                    default: wstrb = 4'b1111;
                endcase
            end
            mem1_pkg::SEL_SWR: begin // offset up to byte 3
                case (byte_off)
                    2'b00:   wstrb = 4'b1111;
                    2'b01:   wstrb = 4'b1110;
                    2'b10:   wstrb = 4'b1100;
                    default: wstrb = 4'b1000;
                endcase
            end
            default: wstrb = 4'b1111; // SW, SC
        endcase
    end

    // store data placed on its lanes
    always_comb begin
        case (dm_sel)
            mem1_pkg::SEL_SB:  wdata = {4{store_data[7:0]}};
            mem1_pkg::SEL_SH:  wdata = {2{store_data[15:0]}};
            mem1_pkg::SEL_SWL: wdata = store_data >> {~byte_off, 3'b000};
            mem1_pkg::SEL_SWR: wdata = store_data << {byte_off, 3'b000};
            default:           wdata = store_data;
        endcase
    end

    // narrow loads: {0, signed, half, offset}
    // lwl/lwr: {1, lane mask}
    always_comb begin
        case (dm_sel)
            mem1_pkg::SEL_LBU: rstrb = {3'b000, byte_off};
            mem1_pkg::SEL_LB:  rstrb = {3'b010, byte_off};
            mem1_pkg::SEL_LHU: rstrb = {3'b001, byte_off[1], 1'b0};
            mem1_pkg::SEL_LH:  rstrb = {3'b011, byte_off[1], 1'b0};
            mem1_pkg::SEL_LWL: begin
                case (byte_off)
                    2'b00:   rstrb = 5'b11000;
                    2'b01:   rstrb = 5'b11100;
                    2'b10:   rstrb = 5'b11110;
                    default: rstrb = 5'b11111;
                endcase
            end
            mem1_pkg::SEL_LWR: begin
                case (byte_off)
                    2'b00:   rstrb = 5'b11111;
                    2'b01:   rstrb = 5'b10111;
                    2'b10:   rstrb = 5'b10011;
                    default: rstrb = 5'b10001;
                endcase
            end
            default: rstrb = 5'b11111; // LW, LL
        endcase
    end

    always_comb begin
        case (dm_sel)
            mem1_pkg::SEL_SB,
            mem1_pkg::SEL_LB,
            mem1_pkg::SEL_LBU: acc_size = mem1_pkg::SIZE_BYTE;
            mem1_pkg::SEL_SH,
            mem1_pkg::SEL_LH,
            mem1_pkg::SEL_LHU: acc_size = mem1_pkg::SIZE_HALF;
            default:           acc_size = mem1_pkg::SIZE_WORD; // partial words move as words
        endcase
    end

endmodule

/* rtl/mem1_addr_xlate.sv */
`timescale 1ns/1ps

module mem1_addr_xlate (
    input  mem1_pkg::vaddr_t vaddr,
    input  logic             req,
    input  mem1_pkg::pfn_t   tlb_pfn,
    input  mem1_pkg::cattr_t tlb_c,
    input  mem1_pkg::cattr_t k0_attr,
    output logic             mapped,
    output mem1_pkg::paddr_t paddr,
    output logic             uncached
);

    logic kseg0;
    logic kseg1;
    logic useg_or_kseg23;

    // kuseg and kseg2/3 go through the tlb
    assign useg_or_kseg23 = ~vaddr[31] | (vaddr[31] & vaddr[30]);
    assign mapped = req & useg_or_kseg23;

    // kseg0/1 just drop the segment bits
    always_comb begin
        if (mapped) begin
            paddr = {tlb_pfn, vaddr[mem1_pkg::PAGE_OFFSET_W-1:0]};
        end else begin
            paddr = {3'b000, vaddr[28:0]};
        end
    end

    assign kseg0 = (vaddr[31:29] == mem1_pkg::SEG_KSEG0);
    assign kseg1 = (vaddr[31:29] == mem1_pkg::SEG_KSEG1);

    // kseg1 is always uncached, kseg0 follows config K0,
    // mapped segments follow the C bits of the matching tlb entry
    always_comb begin
        uncached = 1'b1;
        if (kseg0 && k0_attr == mem1_pkg::CATTR_CACHED) begin
            uncached = 1'b0;
        end else if (!kseg0 && !kseg1 && tlb_c == mem1_pkg::CATTR_CACHED) begin
            uncached = 1'b0;
        end
    end

endmodule

/* rtl/mem1_exc_detect.sv */
`timescale 1ns/1ps

module mem1_exc_detect (
    input  logic                req,
    input  logic                is_load,
    input  logic                is_store,
    input  logic                wr_en,
    input  logic                mapped,
    input  mem1_pkg::vaddr_t    vaddr,
    input  mem1_pkg::vaddr_t    pc,
    input  mem1_pkg::mem_sel_t  dm_sel,
    input  logic                tlb_found,
    input  logic                tlb_v,
    input  logic                tlb_d,
    input  logic                interrupt,
    input  logic                overflow,
    input  logic                trap,
    input  logic                prior_exc,
    input  mem1_pkg::exc_code_t prior_code,
    input  logic                eret_flush,
    output logic                exception,
    output mem1_pkg::exc_code_t exc_code,
    output mem1_pkg::vaddr_t    badvaddr,
    output logic                tlb_refill,
    output logic                flush
);

    logic entry_ok;
    logic tlbl;
    logic tlbs;
    logic tlbmod;
    logic tlb_exc;
    logic ades;
    logic adel;
    logic half_sel;

    // miss and invalid share one code per direction
    assign entry_ok = tlb_found & tlb_v;
    assign tlbl     = mapped & ~wr_en & ~entry_ok;
    assign tlbs     = mapped & wr_en & ~entry_ok;
    assign tlbmod   = mapped & wr_en & entry_ok & ~tlb_d; // page not dirty yet
    assign tlb_exc  = tlbl | tlbs | tlbmod;

    // refill goes to its own vector, so only a real miss counts
    assign tlb_refill = mapped & ~tlb_found & req & ~prior_exc;

    assign half_sel = (dm_sel == mem1_pkg::SEL_LH) || (dm_sel == mem1_pkg::SEL_LHU);

    assign ades = is_store && dm_sel == mem1_pkg::SEL_SH && vaddr[0];
    assign adel = is_load && ((dm_sel == mem1_pkg::SEL_LW && vaddr[1:0] != 2'b00) ||
                              (half_sel && vaddr[0]));

    assign exception = interrupt | prior_exc | overflow | trap | ades | adel | tlb_exc;
    assign flush     = exception | eret_flush;

    // highest priority first
    always_comb begin
        if (interrupt) begin
            exc_code = mem1_pkg::EXC_INT;
            badvaddr = '0;
        end else if (prior_exc) begin
            exc_code = prior_code;
            badvaddr = pc;  // fetch side faults report the pc
        end else if (overflow) begin
            exc_code = mem1_pkg::EXC_OV;
            badvaddr = '0;
        end else if (trap) begin
            exc_code = mem1_pkg::EXC_TR;
            badvaddr = '0;
        end else if (ades) begin
            exc_code = mem1_pkg::EXC_ADES;
            badvaddr = vaddr;
        end else if (adel) begin
            exc_code = mem1_pkg::EXC_ADEL;
            badvaddr = vaddr;
        end else begin
            // tlb tier, also the idle value
            if (tlbl) begin
                exc_code = mem1_pkg::EXC_TLBL;
            end else if (tlbs) begin
                exc_code = mem1_pkg::EXC_TLBS;
            end else begin
                exc_code = mem1_pkg::EXC_MOD;
            end
            badvaddr = vaddr;
        end
    end

endmodule

/* rtl/mem1_llsc_monitor.sv */
`timescale 1ns/1ps

module mem1_llsc_monitor (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req,
    input  logic             is_store,
    input  logic             is_ll,
    input  logic             is_sc,
    input  logic             flush,
    input  mem1_pkg::vaddr_t vaddr,
    output logic             wr_en,
    output logic             mem_en,
    output logic             sc_result
);

    logic             link_valid;
    mem1_pkg::vaddr_t link_addr;
    logic             sc_pass;  // 1 unless an sc has lost its link

    // any flush (exception or eret) breaks the link
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            link_valid <= 1'b0;
        end else if (is_ll) begin
            link_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (is_ll) begin
            link_addr <= vaddr;
        end
    end

    assign sc_result = is_sc & link_valid & (link_addr == vaddr);
    assign sc_pass   = ~is_sc | sc_result;

    assign wr_en  = is_store & sc_pass;
    assign mem_en = req & ~flush & sc_pass;

endmodule

/* rtl/mem1_pkg.sv */
package mem1_pkg;

    // widths with a meaning of their own
    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [31:0] word_t;
    typedef logic [19:0] pfn_t;      // tlb frame number
    typedef logic [2:0]  cattr_t;    // cache attribute, tlb C field or config K0
    typedef logic [3:0]  mem_sel_t;  // access select from decode
    typedef logic [4:0]  exc_code_t; // cause ExcCode field
    typedef logic [3:0]  wstrb_t;
    typedef logic [4:0]  rstrb_t;    // read lane code, see mem1_access_align
    typedef logic [2:0]  acc_size_t;

    // 4 KB pages
    localparam int PAGE_OFFSET_W = 12;

    // top three address bits of the unmapped kernel segments
    localparam logic [2:0] SEG_KSEG0 = 3'b100;
    localparam logic [2:0] SEG_KSEG1 = 3'b101;

    // cacheable noncoherent is the only attribute that goes to the dcache
    localparam cattr_t CATTR_CACHED = 3'd3;

    // exception codes
    localparam exc_code_t EXC_INT  = 5'd0;
    localparam exc_code_t EXC_MOD  = 5'd1;
    localparam exc_code_t EXC_TLBL = 5'd2;
    localparam exc_code_t EXC_TLBS = 5'd3;
    localparam exc_code_t EXC_ADEL = 5'd4;
    localparam exc_code_t EXC_ADES = 5'd5;
    localparam exc_code_t EXC_OV   = 5'd12;
    localparam exc_code_t EXC_TR   = 5'd13;

    // stores, sc uses the SW select
    localparam mem_sel_t SEL_SB  = 4'd0;
    localparam mem_sel_t SEL_SH  = 4'd1;
    localparam mem_sel_t SEL_SW  = 4'd2;
    localparam mem_sel_t SEL_SWL = 4'd3;
    localparam mem_sel_t SEL_SWR = 4'd4;

    // loads, ll uses the LW select
    localparam mem_sel_t SEL_LBU = 4'd5;
    localparam mem_sel_t SEL_LB  = 4'd6;
    localparam mem_sel_t SEL_LHU = 4'd7;
    localparam mem_sel_t SEL_LH  = 4'd8;
    localparam mem_sel_t SEL_LWL = 4'd9;
    localparam mem_sel_t SEL_LWR = 4'd10;
    localparam mem_sel_t SEL_LW  = 4'd11;

    // access size as seen by the cache
    localparam acc_size_t SIZE_BYTE = 3'd0;
    localparam acc_size_t SIZE_HALF = 3'd1;
    localparam acc_size_t SIZE_WORD = 3'd2;

endpackage

/* rtl/mem1_stage.sv */
`timescale 1ns/1ps

module mem1_stage (
    input  logic                clk,
    input  logic                rst_n,
    // access from execute
    input  logic                req,
    input  logic                is_load,
    input  logic                is_store,
    input  logic                is_ll,
    input  logic                is_sc,
    input  mem1_pkg::mem_sel_t  dm_sel,
    input  mem1_pkg::vaddr_t    vaddr,
    input  mem1_pkg::vaddr_t    pc,
    input  mem1_pkg::word_t     store_data,
    // tlb lookup result for vaddr
    input  logic                tlb_found,
    input  logic                tlb_v,
    input  logic                tlb_d,
    input  mem1_pkg::pfn_t      tlb_pfn,
    input  mem1_pkg::cattr_t    tlb_c,
    input  mem1_pkg::cattr_t    k0_attr,
    input  logic                interrupt,
    input  logic                overflow,
    input  logic                trap,
    input  logic                prior_exc,
    input  mem1_pkg::exc_code_t prior_code,
    input  logic                eret_flush,
    output mem1_pkg::paddr_t    paddr,
    output logic                uncached,
    output logic                mem_en,
    output logic                wr_en,
    output mem1_pkg::wstrb_t    wstrb,
    output mem1_pkg::word_t     wdata,
    output mem1_pkg::rstrb_t    rstrb,
    output mem1_pkg::acc_size_t acc_size,
    output logic                exception,
    output mem1_pkg::exc_code_t exc_code,
    output mem1_pkg::vaddr_t    badvaddr,
    output logic                tlb_refill,
    output logic                flush,
    output logic                sc_result
);

    logic mapped;

    mem1_addr_xlate u_xlate (
        .vaddr    (vaddr),
        .req      (req),
        .tlb_pfn  (tlb_pfn),
        .tlb_c    (tlb_c),
        .k0_attr  (k0_attr),
        .mapped   (mapped),
        .paddr    (paddr),
        .uncached (uncached)
    );

    // flush from the exception logic comes back here to drop the link
    mem1_llsc_monitor u_llsc (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .is_store  (is_store),
        .is_ll     (is_ll),
        .is_sc     (is_sc),
        .flush     (flush),
        .vaddr     (vaddr),
        .wr_en     (wr_en),
        .mem_en    (mem_en),
        .sc_result (sc_result)
    );

    mem1_exc_detect u_exc (
        .req        (req),
        .is_load    (is_load),
        .is_store   (is_store),
        .wr_en      (wr_en),
        .mapped     (mapped),
        .vaddr      (vaddr),
        .pc         (pc),
        .dm_sel     (dm_sel),
        .tlb_found  (tlb_found),
        .tlb_v      (tlb_v),
        .tlb_d      (tlb_d),
        .interrupt  (interrupt),
        .overflow   (overflow),
        .trap       (trap),
        .prior_exc  (prior_exc),
        .prior_code (prior_code),
        .eret_flush (eret_flush),
        .exception  (exception),
        .exc_code   (exc_code),
        .badvaddr   (badvaddr),
        .tlb_refill (tlb_refill),
        .flush      (flush)
    );

    mem1_access_align u_align (
        .dm_sel     (dm_sel),
        .byte_off   (paddr[1:0]),
        .store_data (store_data),
        .wstrb      (wstrb),
        .wdata      (wdata),
        .rstrb      (rstrb),
        .acc_size   (acc_size)
    );

endmodule

/* src.f */
rtl/mem1_pkg.sv
rtl/mem1_addr_xlate.sv
rtl/mem1_exc_detect.sv
rtl/mem1_llsc_monitor.sv
rtl/mem1_access_align.sv
rtl/mem1_stage.sv
bench/mem1_asserts.sv
bench/mem1_checker.sv
bench/mem1_tb.sv
